//--- Bender.yml
package:
  name: mmu

sources:
  - mmu_pkg.sv
  - mmu_decode.sv
  - tlb_array.sv
  - mmu_result.sv
  - mmu_top.sv
  - target: simulation
    files:
      - mmu_props.sv
      - tb_mmu.sv

//--- all.f
mmu_pkg.sv
mmu_decode.sv
tlb_array.sv
mmu_result.sv
mmu_top.sv
mmu_props.sv
tb_mmu.sv

//--- mmu_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_decode
    import mmu_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        req_valid,
    input  wire mmu_req_t    req,
    input  wire cp0_update_t cp0_update,
    output logic             lookup_valid,
    output tlb_lookup_t      lookup
);

    logic [31:0] entryhi;
    logic [31:0] entrylo0;
    logic [31:0] entrylo1;
    logic [31:0] index_reg;

    tlb_lookup_t lookup_next;
    tlb_entry_t  w_entry;
    logic [31:0] addr;

    // entrylo layout: pfn 25:6, c 5:3, d 2, v 1, g 0
    always_comb begin
        w_entry.vpn2 = entryhi[31:13];
        w_entry.asid = entryhi[7:0];
        w_entry.g    = entrylo0[0] & entrylo1[0];
        w_entry.pfn0 = entrylo0[25:6];
        w_entry.c0   = entrylo0[5:3];
        w_entry.d0   = entrylo0[2];
        w_entry.v0   = entrylo0[1];
        w_entry.pfn1 = entrylo1[25:6];
        w_entry.c1   = entrylo1[5:3];
        w_entry.d1   = entrylo1[2];
        w_entry.v1   = entrylo1[1];
    end

    always_comb begin
        if (req.op inside {op_set_entryhi, op_set_entrylo0, op_set_entrylo1, op_set_index}) begin
            addr = req.wdata;
        end else begin
            addr = req.vaddr;
        end
        lookup_next.op      = req.op;
        lookup_next.offset  = addr[11:0];
        lookup_next.vpn2    = addr[31:13];
        lookup_next.odd     = addr[12];
        lookup_next.asid    = entryhi[7:0];
        lookup_next.index   = index_reg[tlb_index_w-1:0];
        lookup_next.w_entry = w_entry;
        // probe searches for the page in entryhi
        if (req.op == op_tlbp) begin
            lookup_next.vpn2 = entryhi[31:13];
            lookup_next.odd  = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid <= 1'b0;
            entryhi      <= '0;
            entrylo0     <= '0;
            entrylo1     <= '0;
            index_reg    <= '0;
        end else begin
            lookup_valid <= req_valid;
            if (cp0_update.valid && cp0_update.op == op_tlbp) begin
                index_reg <= {cp0_update.probe_miss, {(31 - tlb_index_w){1'b0}},
                              cp0_update.probe_index};
            end
            if (cp0_update.valid && cp0_update.op == op_tlbr) begin
                entryhi  <= {cp0_update.r_entry.vpn2, 5'b0, cp0_update.r_entry.asid};
                entrylo0 <= {6'b0, cp0_update.r_entry.pfn0, cp0_update.r_entry.c0,
                             cp0_update.r_entry.d0, cp0_update.r_entry.v0,
                             cp0_update.r_entry.g};
                entrylo1 <= {6'b0, cp0_update.r_entry.pfn1, cp0_update.r_entry.c1,
                             cp0_update.r_entry.d1, cp0_update.r_entry.v1,
                             cp0_update.r_entry.g};
            end
            // a register write in the same cycle wins
            if (req_valid) begin
                case (req.op)
                    op_set_entryhi:  entryhi  <= {req.wdata[31:13], 5'b0, req.wdata[7:0]};
                    op_set_entrylo0: entrylo0 <= {6'b0, req.wdata[25:0]};
                    op_set_entrylo1: entrylo1 <= {6'b0, req.wdata[25:0]};
                    op_set_index: begin
                        index_reg <= {{(32 - tlb_index_w){1'b0}},
                                      req.wdata[tlb_index_w-1:0]};
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        lookup <= lookup_next;
    end

endmodule

`default_nettype wire

//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    localparam int tlb_entries = 16;
    localparam int tlb_index_w = $clog2(tlb_entries);
    localparam int mmu_latency = 3;

    typedef enum logic [3:0] {
        op_set_entryhi  = 4'd0,
        op_set_entrylo0 = 4'd1,
        op_set_entrylo1 = 4'd2,
        op_set_index    = 4'd3,
        op_tlbwi        = 4'd4,
        op_tlbr         = 4'd5,
        op_tlbp         = 4'd6,
        op_load         = 4'd7,
        op_store        = 4'd8
    } mmu_op_e;

    typedef enum logic [1:0] {
        exc_none     = 2'd0,
        exc_refill   = 2'd1,
        exc_invalid  = 2'd2,
        exc_modified = 2'd3
    } mmu_exc_e;

    // 78 bits, vpn2 in the top bits
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        mmu_op_e     op;
        logic [31:0] vaddr;
        logic [31:0] wdata;
    } mmu_req_t;

    // set ops carry the written value in vpn2, odd and offset
    typedef struct packed {
        mmu_op_e                op;
        logic [11:0]            offset;
        logic [18:0]            vpn2;
        logic                   odd;
        logic [7:0]             asid;
        logic [tlb_index_w-1:0] index;
        tlb_entry_t             w_entry;
    } tlb_lookup_t;

    typedef struct packed {
        mmu_op_e                op;
        logic [11:0]            offset;
        logic [18:0]            vpn2;
        logic                   odd;
        logic                   found;
        logic [tlb_index_w-1:0] hit_index;
        logic [19:0]            pfn;
        logic                   d;
        logic                   v;
        tlb_entry_t             r_entry;
    } tlb_hit_t;

    typedef struct packed {
        logic                   valid;
        mmu_op_e                op;
        logic                   probe_miss;
        logic [tlb_index_w-1:0] probe_index;
        tlb_entry_t             r_entry;
    } cp0_update_t;

    typedef struct packed {
        mmu_op_e     op;
        mmu_exc_e    exc;
        logic [31:0] data;
    } mmu_resp_t;

endpackage

`default_nettype wire

//--- mmu_props.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_props
    import mmu_pkg::*;
(
    input wire logic      clk,
    input wire logic      reset,
    input wire logic      req_valid,
    input wire logic      resp_valid,
    input wire mmu_resp_t resp
);

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // every request is answered after the pipeline depth
    resp_follows_req: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> ##mmu_latency resp_valid)
    else begin
        fail_count++;
        $error("no response %0d cycles after a request", mmu_latency);
    end

    // and no response without a request
    req_before_resp: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> $past(req_valid, mmu_latency))
    else begin
        fail_count++;
        $error("response without a matching request");
    end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !resp_valid)
    else begin
        fail_count++;
        $error("response strobe high in the cycle after reset");
    end

    set_ops_no_exc: assert property (@(posedge clk) disable iff (reset)
        (resp_valid && resp.op inside {op_set_entryhi, op_set_entrylo0,
                                       op_set_entrylo1, op_set_index})
        |-> resp.exc == exc_none)
    else begin
        fail_count++;
        $error("register write returned an exception");
    end

endmodule

`default_nettype wire

//--- mmu_result.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_result
    import mmu_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     hit_valid,
    input  wire tlb_hit_t hit,
    output logic          resp_valid,
    output mmu_resp_t     resp,
    output cp0_update_t   cp0_update
);

    mmu_resp_t   resp_next;
    cp0_update_t cp0_next;

    always_comb begin
        resp_next.op   = hit.op;
        resp_next.exc  = exc_none;
        resp_next.data = '0;
        case (hit.op)
            op_set_entryhi, op_set_entrylo0, op_set_entrylo1, op_set_index: begin
                resp_next.data = {hit.vpn2, hit.odd, hit.offset};
            end
            op_load, op_store: begin
                if (!hit.found) begin
                    resp_next.exc = exc_refill;
                end else if (!hit.v) begin
                    resp_next.exc = exc_invalid;
                end else if (hit.op == op_store && !hit.d) begin
                    resp_next.exc = exc_modified;
                end
                if (resp_next.exc == exc_none) begin
                    resp_next.data = {hit.pfn, hit.offset};
                end else begin
                    // faulting page, offset cleared
                    resp_next.data = {hit.vpn2, hit.odd, 12'h000};
                end
            end
            op_tlbp: begin
                resp_next.data = {~hit.found, {(31 - tlb_index_w){1'b0}}, hit.hit_index};
            end
            op_tlbr: begin
                resp_next.data = {hit.r_entry.vpn2, 5'b0, hit.r_entry.asid};
            end
            default: ;
        endcase
    end

    always_comb begin
        cp0_next.valid       = hit_valid && (hit.op == op_tlbp || hit.op == op_tlbr);
        cp0_next.op          = hit.op;
        cp0_next.probe_miss  = ~hit.found;
        cp0_next.probe_index = hit.hit_index;
        cp0_next.r_entry     = hit.r_entry;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid       <= 1'b0;
            cp0_update.valid <= 1'b0;
        end else begin
            resp_valid       <= hit_valid;
            cp0_update.valid <= cp0_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        resp                   <= resp_next;
        cp0_update.op          <= cp0_next.op;
        cp0_update.probe_miss  <= cp0_next.probe_miss;
        cp0_update.probe_index <= cp0_next.probe_index;
        cp0_update.r_entry     <= cp0_next.r_entry;
    end

endmodule

`default_nettype wire

//--- mmu_top.sv
`timescale 1ns/100ps
`default_nettype none

module mmu_top
    import mmu_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     req_valid,
    input  wire mmu_req_t req,
    output logic          resp_valid,
    output mmu_resp_t     resp
);

    logic        lookup_valid;
    tlb_lookup_t lookup;
    logic        hit_valid;
    tlb_hit_t    hit;
    cp0_update_t cp0_update;

    mmu_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .cp0_update   (cp0_update),
        .lookup_valid (lookup_valid),
        .lookup       (lookup)
    );

    tlb_array u_tlb (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .hit_valid    (hit_valid),
        .hit          (hit)
    );

    // tlbp and tlbr results loop back to the cp0 registers
    mmu_result u_result (
        .clk        (clk),
        .reset      (reset),
        .hit_valid  (hit_valid),
        .hit        (hit),
        .resp_valid (resp_valid),
        .resp       (resp),
        .cp0_update (cp0_update)
    );

endmodule

`default_nettype wire

//--- tb_mmu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mmu
    import mmu_pkg::*;
();

    typedef struct packed {
        mmu_op_e     op;
        logic [31:0] vaddr;
        logic [31:0] wdata;
        logic [3:0]  gap;
        mmu_exc_e    exc;
        logic [31:0] data;
    } row_t;

    typedef struct packed {
        mmu_op_e     op;
        mmu_exc_e    exc;
        logic [31:0] data;
        logic [31:0] issued;
    } expect_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      req_valid;
    mmu_req_t  req;
    logic      resp_valid;
    mmu_resp_t resp;

    row_t        rows[$];
    expect_t     exp_q[$];
    int unsigned cycle = 0;
    int unsigned cycle_limit = 1000;
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned total;

    mmu_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    bind mmu_top mmu_props u_props (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // entryhi: vpn2 31:13, asid 7:0
    function automatic logic [31:0] make_hi(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    // entrylo: pfn 25:6, c 5:3, d 2, v 1, g 0
    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic d,
                                            input logic v, input logic g);
        return {6'b0, pfn, 3'd3, d, v, g};
    endfunction

    function automatic logic [31:0] virt_addr(input logic [18:0] vpn2, input logic odd,
                                              input logic [11:0] offset);
        return {vpn2, odd, offset};
    endfunction

    function automatic logic [31:0] phys_addr(input logic [19:0] pfn, input logic [31:0] va);
        return {pfn, va[11:0]};
    endfunction

    function automatic logic [31:0] fault_page(input logic [31:0] va);
        return {va[31:12], 12'h000};
    endfunction

    task automatic add_row(input mmu_op_e op, input logic [31:0] vaddr,
                           input logic [31:0] wdata, input int gap,
                           input mmu_exc_e exc, input logic [31:0] data);
        row_t r;
        r.op    = op;
        r.vaddr = vaddr;
        r.wdata = wdata;
        r.gap   = gap[3:0];
        r.exc   = exc;
        r.data  = data;
        rows.push_back(r);
    endtask

    // register writes echo the written value
    task automatic set_reg(input mmu_op_e op, input logic [31:0] value);
        add_row(op, 32'h0, value, 0, exc_none, value);
    endtask

    task automatic load_ok(input logic [31:0] va, input logic [19:0] pfn);
        add_row(op_load, va, 32'h0, 0, exc_none, phys_addr(pfn, va));
    endtask

    task automatic build_table();
        logic [31:0] va;
        // even/odd pair at index 2, both pages valid and dirty
        set_reg(op_set_entryhi, make_hi(19'h00040, 8'h12));
        set_reg(op_set_entrylo0, make_lo(20'h0a001, 1'b1, 1'b1, 1'b0));
        set_reg(op_set_entrylo1, make_lo(20'h0a002, 1'b1, 1'b1, 1'b0));
        set_reg(op_set_index, 32'd2);
        add_row(op_tlbwi, 32'h0, 32'h0, 0, exc_none, 32'h0);
        load_ok(virt_addr(19'h00040, 1'b0, 12'h123), 20'h0a001);
        load_ok(virt_addr(19'h00040, 1'b1, 12'habc), 20'h0a002);
        va = virt_addr(19'h00040, 1'b1, 12'h004);
        add_row(op_store, va, 32'h0, 0, exc_none, phys_addr(20'h0a002, va));
        // unmapped page
        va = virt_addr(19'h00055, 1'b0, 12'h010);
        add_row(op_load, va, 32'h0, 0, exc_refill, fault_page(va));
        // index 5: even page invalid, odd page valid but clean
        set_reg(op_set_entryhi, make_hi(19'h00041, 8'h12));
        set_reg(op_set_entrylo0, make_lo(20'h0b001, 1'b0, 1'b0, 1'b0));
        set_reg(op_set_entrylo1, make_lo(20'h0b002, 1'b0, 1'b1, 1'b0));
        set_reg(op_set_index, 32'd5);
        add_row(op_tlbwi, 32'h0, 32'h0, 0, exc_none, 32'h0);
        va = virt_addr(19'h00041, 1'b0, 12'h020);
        add_row(op_load, va, 32'h0, 0, exc_invalid, fault_page(va));
        add_row(op_store, va, 32'h0, 0, exc_invalid, fault_page(va));
        va = virt_addr(19'h00041, 1'b1, 12'h030);
        add_row(op_store, va, 32'h0, 0, exc_modified, fault_page(va));
        load_ok(va, 20'h0b002);
        // global pair at index 9
        set_reg(op_set_entryhi, make_hi(19'h00042, 8'h12));
        set_reg(op_set_entrylo0, make_lo(20'h0c001, 1'b1, 1'b1, 1'b1));
        set_reg(op_set_entrylo1, make_lo(20'h0c002, 1'b1, 1'b1, 1'b1));
        set_reg(op_set_index, 32'd9);
        add_row(op_tlbwi, 32'h0, 32'h0, 0, exc_none, 32'h0);
        // switch asid
        set_reg(op_set_entryhi, make_hi(19'h00042, 8'h34));
        va = virt_addr(19'h00040, 1'b0, 12'h100);
        add_row(op_load, va, 32'h0, 0, exc_refill, fault_page(va));
        load_ok(virt_addr(19'h00042, 1'b1, 12'h200), 20'h0c002);
        // probe and read back, gaps let the cp0 update land
        set_reg(op_set_entryhi, make_hi(19'h00041, 8'h12));
        add_row(op_tlbp, 32'h0, 32'h0, 4, exc_none, 32'd5);
        add_row(op_tlbr, 32'h0, 32'h0, 4, exc_none, make_hi(19'h00041, 8'h12));
        set_reg(op_set_entryhi, make_hi(19'h00077, 8'h34));
        add_row(op_tlbp, 32'h0, 32'h0, 4, exc_none, 32'h8000_0000);
        set_reg(op_set_index, 32'd2);
        add_row(op_tlbr, 32'h0, 32'h0, 4, exc_none, make_hi(19'h00040, 8'h12));
        // asid 12 restored by tlbr
        load_ok(virt_addr(19'h00040, 1'b1, 12'h3f0), 20'h0a002);
        // back to back
        load_ok(virt_addr(19'h00040, 1'b0, 12'h001), 20'h0a001);
        load_ok(virt_addr(19'h00040, 1'b1, 12'h002), 20'h0a002);
        load_ok(virt_addr(19'h00042, 1'b0, 12'h003), 20'h0c001);
        load_ok(virt_addr(19'h00041, 1'b1, 12'h004), 20'h0b002);
        load_ok(virt_addr(19'h00042, 1'b1, 12'h005), 20'h0c002);
    endtask

    task automatic send_row(input row_t r);
        expect_t e;
        req_valid = 1'b1;
        req.op    = r.op;
        req.vaddr = r.vaddr;
        req.wdata = r.wdata;
        e.op      = r.op;
        e.exc     = r.exc;
        e.data    = r.data;
        e.issued  = cycle;
        exp_q.push_back(e);
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        expect_t e;
        if (!reset && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected response at %0t with no request outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                if (resp.op != e.op) begin
                    $display("Error at %0t: resp.op = %s, expected %s",
                             $time, resp.op.name(), e.op.name());
                    errors++;
                end
                if (resp.exc != e.exc) begin
                    $display("Error at %0t: resp.exc = %s, expected %s",
                             $time, resp.exc.name(), e.exc.name());
                    errors++;
                end
                if (resp.data != e.data) begin
                    $display("Error at %0t: resp.data = %h, expected %h",
                             $time, resp.data, e.data);
                    errors++;
                end
                if (cycle - e.issued != mmu_latency) begin
                    $display("response at %0t came %0d cycles after its request",
                             $time, cycle - e.issued);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cycle >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d responses missing",
                     cycle, exp_q.size());
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        cycle_limit = rows.size() * 4 + 20;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        foreach (rows[i]) begin
            send_row(rows[i]);
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            repeat (rows[i].gap) begin
                @(posedge clk);
                #1;
            end
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // catch any stray response
        repeat (mmu_latency + 2) @(posedge clk);
        total = errors + dut0.u_props.fail_count;
        $display("%0d responses checked, %0d errors, %0d assertion failures",
                 checks, errors, dut0.u_props.fail_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb_array.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_array
    import mmu_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        lookup_valid,
    input  wire tlb_lookup_t lookup,
    output logic             hit_valid,
    output tlb_hit_t         hit
);

    tlb_entry_t mem [tlb_entries];
    logic [tlb_entries-1:0] used;

    logic                   found;
    logic [tlb_index_w-1:0] match_index;
    tlb_entry_t             sel;
    tlb_hit_t               hit_next;
    logic                   do_write;

    assign do_write = lookup_valid && lookup.op == op_tlbwi;

    // associative search, highest matching slot wins
    always_comb begin
        found       = 1'b0;
        match_index = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (used[i] && mem[i].vpn2 == lookup.vpn2 &&
                (mem[i].g || mem[i].asid == lookup.asid)) begin
                found       = 1'b1;
                match_index = tlb_index_w'(i);
            end
        end
    end

    assign sel = mem[match_index];

    always_comb begin
        hit_next.op        = lookup.op;
        hit_next.offset    = lookup.offset;
        hit_next.vpn2      = lookup.vpn2;
        hit_next.odd       = lookup.odd;
        hit_next.found     = found;
        hit_next.hit_index = match_index;
        // even/odd page of the pair
        if (lookup.odd) begin
            hit_next.pfn = sel.pfn1;
            hit_next.d   = sel.d1;
            hit_next.v   = sel.v1;
        end else begin
            hit_next.pfn = sel.pfn0;
            hit_next.d   = sel.d0;
            hit_next.v   = sel.v0;
        end
        hit_next.r_entry = mem[lookup.index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_valid <= 1'b0;
            used      <= '0;
        end else begin
            hit_valid <= lookup_valid;
            if (do_write) begin
                used[lookup.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[lookup.index] <= lookup.w_entry;
        end
    end

    // tlbr in the same cycle as a tlbwi sees the old entry
    always_ff @(posedge clk) begin
        hit <= hit_next;
    end

endmodule

`default_nettype wire
